/* dma_trans.f */
hw/dma_trans_pkg.sv
hw/ctrl_arbiter.sv
hw/trans_allocator.sv
hw/cmd_queue.sv
hw/transfer_engine.sv
hw/dma_trans_top.sv
tests/tb_dma_trans.sv

/* run.sh */
#!/bin/sh
# Build and run the dma_trans testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_dma_trans -f dma_trans.f -o sim_dma_trans

out=$(./obj_dir/sim_dma_trans)
echo "$out"

if echo "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1

/* tests/tb_dma_trans.sv */
/*
 * DMA transfer-slot manager testbench
 * Random requests from every controller, checked against a slot model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_trans;
   import dma_trans_pkg::*;

   localparam int BOUND   = (QUEUE_DEPTH + 1) * ((1 << LEN_W) + 2);   // Accept to termination
   localparam int NB_REQS = 300;
   localparam int LIMIT   = NB_REQS * BOUND + 200;                    // Plus drain margin

   logic                           clk_i;
   logic                           rst_ni;
   logic [NB_CTRLS-1:0]            req_valid_i;
   dma_req_t [NB_CTRLS-1:0]        req_i;
   logic [NB_CTRLS-1:0]            req_ready_o;
   logic [NB_CTRLS-1:0][SID_W-1:0] sid_o;
   sid_vec_t [NB_CTRLS-1:0]        clr_i;
   sid_vec_t                       status_o;
   logic [NB_CTRLS-1:0]            evt_o;
   logic [NB_CTRLS-1:0]            int_o;

   // ********************************************************
   // Model state
   // ********************************************************
   sid_vec_t            busy_m;
   sid_vec_t            clr_now;            // Clears driven this cycle
   term_info_t          info_m  [NB_TRANSFERS];
   int                  clr_at  [NB_TRANSFERS];
   int                  evt_exp [NB_CTRLS];
   int                  int_exp [NB_CTRLS];
   int                  evt_got [NB_CTRLS];
   int                  int_got [NB_CTRLS];
   logic [NB_CTRLS-1:0] granted;
   int                  cyc, issued, accepted, pulses, errors, checks;
   int                  owed;               // Accepts whose flags ask for a pulse
   int unsigned         tmo_cnt;
   integer              seed;
   logic [31:0]         rnd;

   dma_trans_top DUT (
      .clk_i, .rst_ni, .req_valid_i, .req_i, .req_ready_o, .sid_o,
      .clr_i, .status_o, .evt_o, .int_o
   );

   initial
   begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task report_error(input string msg);
      errors++;
      $display("CHECK FAILED @%0t: %s", $time, msg);
   endtask

   function automatic logic [SID_W-1:0] lowest_free(sid_vec_t v);
      logic [SID_W-1:0] r;
      r = '0;
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         if (!v[i])
         begin
            r = SID_W'(i);
            break;
         end
      end
      return r;
   endfunction

   // Clear due slots and book the pulses their termination owes
   task drive_clears();
      clr_i   = '0;
      clr_now = '0;
      for (int s = 0; s < NB_TRANSFERS; s++)
      begin
         if (busy_m[s] && cyc == clr_at[s])
         begin
            clr_i[info_m[s].cid][s] = 1'b1;
            clr_now[s] = 1'b1;
            for (int c = 0; c < NB_CTRLS; c++)
            begin
               if (info_m[s].ble || info_m[s].cid == CID_W'(c))
               begin
                  evt_exp[c] += int'(info_m[s].ele);
                  int_exp[c] += int'(info_m[s].ile);
               end
            end
         end
      end
   endtask

   task drive_requests();
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         if (granted[c])
            req_valid_i[c] = 1'b0;   // Accepted at the last edge
         if (!req_valid_i[c] && issued < NB_REQS && ($random(seed) & 3) != 0)
         begin
            rnd            = $random(seed);
            req_i[c]       = rnd[$bits(dma_req_t)-1:0];
            req_valid_i[c] = 1'b1;
            issued++;
         end
      end
      granted = '0;
   endtask

   task check_cycle();
      sid_vec_t         set_m;
      logic [SID_W-1:0] exp_sid;
      set_m = '0;
      checks++;
      if (status_o !== busy_m)
         report_error($sformatf("status %b, expected %b", status_o, busy_m));
      if (&busy_m && req_ready_o != '0)
         report_error("ready high while every slot is busy");
      if ((req_ready_o & (req_ready_o - 1'b1)) != '0)
         report_error($sformatf("ready %b has more than one bit", req_ready_o));
      if ((evt_o | int_o) != '0)
      begin
         if (pulses >= owed)
            report_error("pulse with no termination outstanding");
         pulses++;
      end
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         evt_got[c] += int'(evt_o[c]);
         int_got[c] += int'(int_o[c]);
         if (req_valid_i[c] && req_ready_o[c])
         begin
            exp_sid = lowest_free(busy_m);
            if (sid_o[c] != exp_sid)
               report_error($sformatf("ctrl %0d sid %0d, expected %0d", c, sid_o[c], exp_sid));
            info_m[exp_sid] = '{cid: CID_W'(c), ele: req_i[c].ele,
                                ile: req_i[c].ile, ble: req_i[c].ble};
            rnd             = $random(seed);
            clr_at[exp_sid] = cyc + BOUND + int'(rnd[2:0]);   // 0 to 7 extra
            set_m[exp_sid]  = 1'b1;
            granted[c]      = 1'b1;
            accepted++;
            if (req_i[c].ele || req_i[c].ile)
               owed++;   // The owner always sees this one
         end
      end
      busy_m = (busy_m | set_m) & ~clr_now;
   endtask

   task run_cycle();
      @(negedge clk_i);
      cyc++;
      drive_clears();
      drive_requests();
      #1;
      check_cycle();
   endtask

   // ********************************************************
   // Main sequence
   // ********************************************************
   initial
   begin
      seed        = 32'hdd2f;
      rst_ni      = 1'b0;
      req_valid_i = '0;
      req_i       = '0;
      clr_i       = '0;
      busy_m      = '0;
      clr_now     = '0;
      granted     = '0;
      cyc         = 0;
      issued      = 0;
      accepted    = 0;
      owed        = 0;
      pulses      = 0;
      errors      = 0;
      checks      = 0;
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         evt_exp[c] = 0;
         int_exp[c] = 0;
         evt_got[c] = 0;
         int_got[c] = 0;
      end
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      #1;
      checks++;
      if (status_o != '0 || evt_o != '0 || int_o != '0 || req_ready_o != '0)
         report_error("outputs not idle after reset");
      while (!(accepted == NB_REQS && busy_m == '0))
         run_cycle();
      repeat (2 * NB_TRANSFERS + 4) run_cycle();   // Let the last pulses out
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         checks++;
         if (evt_got[c] != evt_exp[c] || int_got[c] != int_exp[c])
            report_error($sformatf("ctrl %0d evt %0d/%0d int %0d/%0d", c,
                                   evt_got[c], evt_exp[c], int_got[c], int_exp[c]));
      end
      $display("Summary: %0d accepts, %0d checks, %0d errors", accepted, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // Watchdog
   initial
   begin
      tmo_cnt = 0;
      while (tmo_cnt < LIMIT)
      begin
         @(posedge clk_i);
         tmo_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* hw/dma_trans_top.sv */
/*
 * DMA transfer-slot manager top level
 */
`timescale 1ns/1ns
`default_nettype none

module dma_trans_top (
   input  wire logic                                                clk_i,
   input  wire logic                                                rst_ni,
   input  wire logic [dma_trans_pkg::NB_CTRLS-1:0]                  req_valid_i,
   input  wire dma_trans_pkg::dma_req_t [dma_trans_pkg::NB_CTRLS-1:0] req_i,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       req_ready_o,
   output logic [dma_trans_pkg::NB_CTRLS-1:0][dma_trans_pkg::SID_W-1:0] sid_o,
   input  wire dma_trans_pkg::sid_vec_t [dma_trans_pkg::NB_CTRLS-1:0] clr_i,
   output dma_trans_pkg::sid_vec_t                                  status_o,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       evt_o,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       int_o
);
   import dma_trans_pkg::*;

   logic             arb_valid;
   dma_req_t         arb_req;
   logic [CID_W-1:0] arb_cid;
   logic             arb_ready;
   logic [SID_W-1:0] alloc_sid;
   logic             push_valid, push_ready;
   dma_cmd_t         push_cmd;
   logic             pop_valid, pop_ready;
   dma_cmd_t         pop_cmd;
   sid_vec_t         term_sig;

   assign sid_o = {NB_CTRLS{alloc_sid}};   // Same sid seen by every controller

   ctrl_arbiter u_arbiter (
      .clk_i, .rst_ni, .req_valid_i, .req_i, .req_ready_o,
      .arb_valid_o (arb_valid), .arb_req_o (arb_req),
      .arb_cid_o   (arb_cid),   .arb_ready_i (arb_ready)
   );

   trans_allocator u_allocator (
      .clk_i, .rst_ni,
      .arb_valid_i (arb_valid), .arb_req_i (arb_req), .arb_cid_i (arb_cid),
      .arb_ready_o (arb_ready), .sid_o (alloc_sid),
      .push_valid_o (push_valid), .push_cmd_o (push_cmd), .push_ready_i (push_ready),
      .clr_i, .term_sig_i (term_sig), .status_o, .evt_o, .int_o
   );

   cmd_queue #(.T(dma_cmd_t), .DEPTH(QUEUE_DEPTH)) u_queue (
      .clk_i, .rst_ni,
      .push_valid_i (push_valid), .push_data_i (push_cmd), .push_ready_o (push_ready),
      .pop_valid_o  (pop_valid),  .pop_data_o  (pop_cmd),  .pop_ready_i  (pop_ready)
   );

   transfer_engine u_engine (
      .clk_i, .rst_ni,
      .cmd_valid_i (pop_valid), .cmd_i (pop_cmd), .cmd_ready_o (pop_ready),
      .term_sig_o  (term_sig)
   );

endmodule

`default_nettype wire

/* hw/transfer_engine.sv */
/*
 * Transfer engine model
 * Runs one command at a time for len+1 cycles, then signals its termination
 */
`timescale 1ns/1ns
`default_nettype none

module transfer_engine (
   input  wire logic                    clk_i,
   input  wire logic                    rst_ni,
   input  wire logic                    cmd_valid_i,
   input  wire dma_trans_pkg::dma_cmd_t cmd_i,
   output logic                         cmd_ready_o,
   output dma_trans_pkg::sid_vec_t      term_sig_o
);
   import dma_trans_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_RUN
   } state_e;

   state_e           state_q;
   logic [LEN_W-1:0] cnt_q;     // Cycles left after this one
   logic [SID_W-1:0] sid_q;
   sid_vec_t         term_q;
   logic             done;

   assign cmd_ready_o = (state_q == ST_IDLE);
   assign done        = (state_q == ST_RUN) && (cnt_q == '0);
   assign term_sig_o  = term_q;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         term_q  <= '0;
      end
      else
      begin
         term_q <= done ? (sid_vec_t'(1) << sid_q) : '0;   // One-cycle pulse
         case (state_q)
            ST_IDLE:
            begin
               if (cmd_valid_i)
               begin
                  state_q <= ST_RUN;
                  cnt_q   <= cmd_i.len;
               end
            end
            ST_RUN:
            begin
               if (done)
                  state_q <= ST_IDLE;
               else
                  cnt_q <= cnt_q - 1'b1;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Current sid held for the termination pulse
   always_ff @(posedge clk_i)
   begin
      if (cmd_valid_i && cmd_ready_o)
         sid_q <= cmd_i.sid;
   end

endmodule

`default_nettype wire

/* hw/cmd_queue.sv */
/*
 * Command queue
 * Circular-buffer FIFO of any payload type, valid/ready on both sides
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_queue #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  wire logic clk_i,
   input  wire logic rst_ni,
   input  wire logic push_valid_i,
   input  wire T     push_data_i,
   output logic      push_ready_o,
   output logic      pop_valid_o,
   output T          pop_data_o,
   input  wire logic pop_ready_i
);
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T                 mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_push;
   logic             do_pop;

   assign push_ready_o = (count_q != CNT_W'(DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign pop_data_o   = mem_q[rd_ptr_q];
   assign do_push      = push_valid_i & push_ready_o;
   assign do_pop       = pop_valid_o & pop_ready_i;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (do_push && !do_pop)
            count_q <= count_q + 1'b1;
         else if (do_pop && !do_push)
            count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= push_data_i;
   end

   // A push into a full queue would carry the count past the depth
   a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
      count_q <= CNT_W'(DEPTH))
      else $error("Push into a full queue");

endmodule

`default_nettype wire

/* hw/trans_allocator.sv */
/*
 * Transfer slot allocator
 * Hands out sids, tracks busy slots and routes completion events and interrupts
 */
`timescale 1ns/1ns
`default_nettype none

module trans_allocator (
   input  wire logic                                                clk_i,
   input  wire logic                                                rst_ni,
   input  wire logic                                                arb_valid_i,
   input  wire dma_trans_pkg::dma_req_t                             arb_req_i,
   input  wire logic [dma_trans_pkg::CID_W-1:0]                     arb_cid_i,
   output logic                                                     arb_ready_o,
   output logic [dma_trans_pkg::SID_W-1:0]                          sid_o,
   output logic                                                     push_valid_o,
   output dma_trans_pkg::dma_cmd_t                                  push_cmd_o,
   input  wire logic                                                push_ready_i,
   input  wire dma_trans_pkg::sid_vec_t [dma_trans_pkg::NB_CTRLS-1:0] clr_i,
   input  wire dma_trans_pkg::sid_vec_t                             term_sig_i,
   output dma_trans_pkg::sid_vec_t                                  status_o,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       evt_o,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       int_o
);
   import dma_trans_pkg::*;

   sid_vec_t         busy_q;
   sid_vec_t         clr_all;
   logic [SID_W-1:0] free_sid;
   logic             any_free;
   logic             accept;

   term_info_t       tbl_q  [NB_TRANSFERS];   // Routing info per slot
   term_info_t       tbuf_q [NB_TRANSFERS];   // Copy taken at termination
   sid_vec_t         pend_q;                  // Terminations not yet delivered
   logic             ser_valid;
   logic [SID_W-1:0] ser_sid;
   term_info_t       ser_info;

   // ********************************************************
   // Slot allocation
   // ********************************************************
   always_comb
   begin
      free_sid = '0;
      for (int i = NB_TRANSFERS - 1; i >= 0; i--)
      begin
         if (!busy_q[i])
         begin
            free_sid = SID_W'(i);   // Last hit is the lowest free slot
         end
      end
   end

   assign any_free     = ~&busy_q;
   assign arb_ready_o  = any_free & push_ready_i;
   assign accept       = arb_valid_i & arb_ready_o;
   assign sid_o        = free_sid;
   assign push_valid_o = arb_valid_i & any_free;
   assign push_cmd_o   = '{sid: free_sid, len: arb_req_i.len};
   assign status_o     = busy_q;

   // Clear masks from every controller merged
   always_comb
   begin
      clr_all = '0;
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         clr_all |= clr_i[c];
      end
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         busy_q <= '0;
      end
      else
      begin
         busy_q <= (busy_q | (sid_vec_t'(accept) << free_sid)) & ~clr_all;   // Clear wins
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         tbl_q[free_sid] <= '{cid: arb_cid_i, ele: arb_req_i.ele,
                              ile: arb_req_i.ile, ble: arb_req_i.ble};
      end
   end

   // ********************************************************
   // Termination buffering and serialization
   // ********************************************************
   always_comb
   begin
      ser_valid = 1'b0;
      ser_sid   = '0;
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         if (pend_q[i])
         begin
            ser_valid = 1'b1;
            ser_sid   = SID_W'(i);   // Highest pending index wins
         end
      end
   end

   assign ser_info = tbuf_q[ser_sid];

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         pend_q <= '0;
      end
      else
      begin
         pend_q <= term_sig_i | (pend_q & ~(sid_vec_t'(ser_valid) << ser_sid));
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         if (term_sig_i[i])
         begin
            tbuf_q[i] <= tbl_q[i];
         end
      end
   end

   // Broadcast reaches everyone, otherwise only the owner
   always_comb
   begin
      evt_o = '0;
      int_o = '0;
      for (int c = 0; c < NB_CTRLS; c++)
      begin
         if (ser_valid && (ser_info.ble || ser_info.cid == CID_W'(c)))
         begin
            evt_o[c] = ser_info.ele;
            int_o[c] = ser_info.ile;
         end
      end
   end

   a_term_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (term_sig_i & ~busy_q) == '0)
      else $error("Termination for a slot that is not busy");

   a_push_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_valid_o |-> !busy_q[push_cmd_o.sid])
      else $error("Command pushed for a busy slot");

endmodule

`default_nettype wire

/* hw/ctrl_arbiter.sv */
/*
 * Controller request arbiter
 * Round-robin choice among the controllers' valid/ready request channels
 */
`timescale 1ns/1ns
`default_nettype none

module ctrl_arbiter (
   input  wire logic                                                clk_i,
   input  wire logic                                                rst_ni,
   input  wire logic [dma_trans_pkg::NB_CTRLS-1:0]                  req_valid_i,
   input  wire dma_trans_pkg::dma_req_t [dma_trans_pkg::NB_CTRLS-1:0] req_i,
   output logic [dma_trans_pkg::NB_CTRLS-1:0]                       req_ready_o,
   output logic                                                     arb_valid_o,
   output dma_trans_pkg::dma_req_t                                  arb_req_o,
   output logic [dma_trans_pkg::CID_W-1:0]                          arb_cid_o,
   input  wire logic                                                arb_ready_i
);
   import dma_trans_pkg::*;

   logic [CID_W-1:0] rr_q;      // Highest-priority controller this cycle
   logic [CID_W-1:0] win_cid;
   logic             found;

   // Search from the pointer upwards, wrapping around
   always_comb
   begin
      int unsigned idx;
      found   = 1'b0;
      win_cid = '0;
      for (int unsigned k = 0; k < NB_CTRLS; k++)
      begin
         idx = (int'(rr_q) + k) % NB_CTRLS;
         if (!found && req_valid_i[idx])
         begin
            found   = 1'b1;
            win_cid = CID_W'(idx);
         end
      end
   end

   assign arb_valid_o = found;
   assign arb_req_o   = req_i[win_cid];
   assign arb_cid_o   = win_cid;

   always_comb
   begin
      req_ready_o = '0;
      req_ready_o[win_cid] = found & arb_ready_i;   // Only the winner sees ready
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         rr_q <= '0;
      end
      else if (found && arb_ready_i)
      begin
         rr_q <= (win_cid == CID_W'(NB_CTRLS - 1)) ? '0 : win_cid + 1'b1;
      end
   end

   a_one_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(req_ready_o))
      else $error("More than one controller granted");

endmodule

`default_nettype wire

/* hw/dma_trans_pkg.sv */
/*
 * DMA transfer-slot manager shared definitions
 * Sizes, request and command bundles, termination table entry
 */
`default_nettype none

package dma_trans_pkg;

   // ********************************************************
   // Sizes
   // ********************************************************
   localparam int NB_CTRLS     = 2;   // Requesting controllers
   localparam int NB_TRANSFERS = 4;   // Transfer slots
   localparam int SID_W        = 2;   // Slot id width
   localparam int CID_W        = 1;   // Controller index width
   localparam int LEN_W        = 4;
   localparam int QUEUE_DEPTH  = 4;   // Command queue entries

   // One bit per transfer slot
   typedef logic [NB_TRANSFERS-1:0] sid_vec_t;

   // Request from one controller
   typedef struct packed {
      logic [LEN_W-1:0] len;
      logic             ele;   // Event enable
      logic             ile;   // Interrupt enable
      logic             ble;   // Broadcast enable
   } dma_req_t;

   // Command handed to the transfer engine
   typedef struct packed {
      logic [SID_W-1:0] sid;
      logic [LEN_W-1:0] len;
   } dma_cmd_t;

   // Completion routing info kept per slot
   typedef struct packed {
      logic [CID_W-1:0] cid;   // Owner controller
      logic             ele;
      logic             ile;
      logic             ble;
   } term_info_t;

endpackage

`default_nettype wire
